// File: tile_mon_pkg.sv
// Tile count, bus widths, console addresses, sentinel encodings and enums
`default_nettype none

package tile_mon_pkg;

  // Array size
  localparam int N_TILES = 4;
  localparam int TILE_W  = 2;

  // Snooped bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int CHAR_W = 8;

  // Console peripheral, aliased for every tile
  localparam logic [ADDR_W-1:0] STDOUT_ADDR = 32'hFFFF_0004;
  localparam logic [ADDR_W-1:0] STDERR_ADDR = 32'hFFFF_0000;

  localparam logic [CHAR_W-1:0] NEWLINE_CHAR = 8'h0A;

  // Sentinels are addi x0 encodings, so they do nothing on the core
  localparam int                 INSTR_W    = 32;
  localparam logic [INSTR_W-1:0] SENT_START = 32'h5AA0_0013;
  localparam logic [INSTR_W-1:0] SENT_END   = 32'h5FF0_0013;

  localparam int SENT_OVERHEAD = 1;
  localparam int CYCLE_W       = 32;

  // Per-tile line storage
  localparam int LINE_DEPTH = 16;
  localparam int LINE_PTR_W = 4;

  typedef enum logic [1:0] {
    CK_NONE   = 2'd0,
    CK_STDOUT = 2'd1,
    CK_STDERR = 2'd2
  } console_kind_e;

  typedef enum logic {
    DS_IDLE   = 1'b0,
    DS_STREAM = 1'b1
  } drain_state_e;

endpackage

`default_nettype wire

// File: console_decoder.sv
// Console write decoder for one tile, giving character strobes and the exit code
`timescale 1ns/1ps
`default_nettype none

module console_decoder (
  input  logic                              clk,
  input  logic                              i_rst_n,
  input  logic                              i_aw_valid,
  input  logic [tile_mon_pkg::ADDR_W-1:0]   i_aw_addr,
  input  logic                              i_w_valid,
  input  logic [tile_mon_pkg::DATA_W-1:0]   i_w_data,
  output logic                              o_char_valid,
  output logic [tile_mon_pkg::CHAR_W-1:0]   o_char_data,
  output logic                              o_exit_valid,
  output logic [tile_mon_pkg::CHAR_W-1:0]   o_exit_code
);
  import tile_mon_pkg::*;

  console_kind_e arm_q;
  console_kind_e arm_d;
  console_kind_e aw_kind;
  console_kind_e use_kind;

  // Kind of write announced on AW this cycle
  always_comb begin
    aw_kind = CK_NONE;
    if (i_aw_valid && i_aw_addr == STDOUT_ADDR) begin
      aw_kind = CK_STDOUT;
    end else if (i_aw_valid && i_aw_addr == STDERR_ADDR) begin
      aw_kind = CK_STDERR;
    end
  end

  // W beats follow AW order, so a pending arm is older than a new AW
  assign use_kind = (arm_q != CK_NONE) ? arm_q : aw_kind;

  always_comb begin
    arm_d = arm_q;
    if (i_w_valid) begin
      arm_d = (arm_q != CK_NONE) ? aw_kind : CK_NONE;
    end else if (aw_kind != CK_NONE) begin
      arm_d = aw_kind;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      arm_q        <= CK_NONE;
      o_char_valid <= 1'b0;
      o_exit_valid <= 1'b0;
    end else begin
      arm_q        <= arm_d;
      o_char_valid <= i_w_valid && (use_kind == CK_STDOUT);
      // Exit flag is sticky until reset
      if (i_w_valid && use_kind == CK_STDERR) begin
        o_exit_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_w_valid && use_kind == CK_STDOUT) begin
      o_char_data <= i_w_data[CHAR_W-1:0];
    end
    if (i_w_valid && use_kind == CK_STDERR) begin
      o_exit_code <= i_w_data[CHAR_W-1:0];
    end
  end

  // One W beat feeds either the console or the exit code, never both
  a_char_xor_exit: assert property (@(posedge clk) disable iff (!i_rst_n)
    !(o_char_valid && $rose(o_exit_valid)));

endmodule

`default_nettype wire

// File: console_line_buffer.sv
// Per-tile character FIFO with a count of complete lines
`timescale 1ns/1ps
`default_nettype none

module console_line_buffer (
  input  logic                              clk,
  input  logic                              i_rst_n,
  input  logic                              i_push,
  input  logic [tile_mon_pkg::CHAR_W-1:0]   i_char,
  input  logic                              i_pop,
  output logic                              o_line_ready,
  output logic [tile_mon_pkg::CHAR_W-1:0]   o_head_char
);
  import tile_mon_pkg::*;

  logic [CHAR_W-1:0]     mem [LINE_DEPTH];
  logic [LINE_PTR_W-1:0] wr_ptr_q;
  logic [LINE_PTR_W-1:0] rd_ptr_q;
  logic [LINE_PTR_W:0]   count_q;
  logic [LINE_PTR_W:0]   lines_q;
  logic                  full;
  logic                  push_nl;
  logic                  pop_nl;

  assign full    = (count_q == (LINE_PTR_W+1)'(LINE_DEPTH));
  assign push_nl = i_push && (i_char == NEWLINE_CHAR);
  assign pop_nl  = i_pop && (o_head_char == NEWLINE_CHAR);

  // Head is read straight from the array
  assign o_head_char  = mem[rd_ptr_q];
  assign o_line_ready = (lines_q != '0);

  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[wr_ptr_q] <= i_char;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (i_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({i_push, i_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Complete lines held in the FIFO
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      lines_q <= '0;
    end else begin
      case ({push_nl, pop_nl})
        2'b10:   lines_q <= lines_q + 1'b1;
        2'b01:   lines_q <= lines_q - 1'b1;
        default: lines_q <= lines_q;
      endcase
    end
  end

  // The decoder cannot be stalled, so the stimulus must leave room
  a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n)
    !(i_push && full && !i_pop));

  // The drain only pops tiles that hold a whole line
  a_pop_needs_line: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_pop |-> o_line_ready);

endmodule

`default_nettype wire

// File: console_line_drain.sv
// Round-robin drain that streams whole lines from the tile buffers
`timescale 1ns/1ps
`default_nettype none

module console_line_drain (
  input  logic                                                  clk,
  input  logic                                                  i_rst_n,
  input  logic [tile_mon_pkg::N_TILES-1:0]                      i_line_ready,
  input  logic [tile_mon_pkg::N_TILES-1:0][tile_mon_pkg::CHAR_W-1:0] i_head_char,
  output logic [tile_mon_pkg::N_TILES-1:0]                      o_pop,
  output logic                                                  o_out_valid,
  output logic [tile_mon_pkg::TILE_W-1:0]                       o_out_tile,
  output logic [tile_mon_pkg::CHAR_W-1:0]                       o_out_char,
  output logic                                                  o_out_last
);
  import tile_mon_pkg::*;

  drain_state_e      state_q;
  logic [TILE_W-1:0] grant_q;
  logic [TILE_W-1:0] last_q;
  logic [TILE_W-1:0] pick;
  logic [CHAR_W-1:0] cur_char;
  logic              cur_nl;

  // Search from the tile after the last grant, nearest candidate wins
  always_comb begin
    pick = last_q;
    for (int k = N_TILES; k >= 1; k--) begin
      if (i_line_ready[TILE_W'(last_q + k)]) begin
        pick = TILE_W'(last_q + k);
      end
    end
  end

  assign cur_char = i_head_char[grant_q];
  assign cur_nl   = (cur_char == NEWLINE_CHAR);

  always_comb begin
    o_pop = '0;
    if (state_q == DS_STREAM) begin
      o_pop[grant_q] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q     <= DS_IDLE;
      grant_q     <= '0;
      last_q      <= TILE_W'(N_TILES - 1);
      o_out_valid <= 1'b0;
      o_out_last  <= 1'b0;
    end else begin
      o_out_valid <= (state_q == DS_STREAM);
      o_out_last  <= (state_q == DS_STREAM) && cur_nl;
      case (state_q)
        DS_IDLE: begin
          if (|i_line_ready) begin
            grant_q <= pick;
            state_q <= DS_STREAM;
          end
        end
        DS_STREAM: begin
          // Line ends with its newline
          if (cur_nl) begin
            last_q  <= grant_q;
            state_q <= DS_IDLE;
          end
        end
        default: state_q <= DS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    o_out_tile <= grant_q;
    o_out_char <= cur_char;
  end

  a_pop_onehot: assert property (@(posedge clk) disable iff (!i_rst_n)
    $onehot0(o_pop));

endmodule

`default_nettype wire

// File: sync_profiler.sv
// Cycle counter, sentinel stamping and global synchronization-time report
`timescale 1ns/1ps
`default_nettype none

module sync_profiler (
  input  logic                                                     clk,
  input  logic                                                     i_rst_n,
  input  logic [tile_mon_pkg::N_TILES-1:0]                         i_ex_valid,
  input  logic [tile_mon_pkg::N_TILES-1:0][tile_mon_pkg::INSTR_W-1:0] i_ex_instr,
  output logic                                                     o_sync_valid,
  output logic [tile_mon_pkg::CYCLE_W-1:0]                         o_sync_cycles
);
  import tile_mon_pkg::*;

  logic [CYCLE_W-1:0] cycle_q;
  logic [N_TILES-1:0] started_q;
  logic [N_TILES-1:0] ended_q;
  logic [N_TILES-1:0] started_d;
  logic [N_TILES-1:0] ended_d;
  logic [CYCLE_W-1:0] last_start_q;
  logic [CYCLE_W-1:0] last_end_q;
  logic [CYCLE_W-1:0] last_start_d;
  logic [CYCLE_W-1:0] last_end_d;
  logic               new_start;
  logic               new_end;
  logic               all_ended;

  // Only the first sentinel of each kind per tile and iteration is kept
  always_comb begin
    started_d = started_q;
    ended_d   = ended_q;
    new_start = 1'b0;
    new_end   = 1'b0;
    for (int t = 0; t < N_TILES; t++) begin
      if (i_ex_valid[t] && i_ex_instr[t] == SENT_START && !started_q[t]) begin
        started_d[t] = 1'b1;
        new_start    = 1'b1;
      end
      if (i_ex_valid[t] && i_ex_instr[t] == SENT_END && !ended_q[t]) begin
        ended_d[t] = 1'b1;
        new_end    = 1'b1;
      end
    end
  end

  // The counter only grows, so the newest stamp is also the largest
  assign last_start_d = new_start ? cycle_q : last_start_q;
  assign last_end_d   = new_end ? cycle_q : last_end_q;
  assign all_ended    = &ended_d;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cycle_q      <= '0;
      started_q    <= '0;
      ended_q      <= '0;
      last_start_q <= '0;
      last_end_q   <= '0;
      o_sync_valid <= 1'b0;
    end else begin
      cycle_q      <= cycle_q + 1'b1;
      o_sync_valid <= all_ended;
      if (all_ended) begin
        // Iteration complete, start over on the next cycle
        started_q    <= '0;
        ended_q      <= '0;
        last_start_q <= '0;
        last_end_q   <= '0;
      end else begin
        started_q    <= started_d;
        ended_q      <= ended_d;
        last_start_q <= last_start_d;
        last_end_q   <= last_end_d;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (all_ended) begin
      o_sync_cycles <= last_end_d - last_start_d - CYCLE_W'(SENT_OVERHEAD);
    end
  end

  // Report is a single pulse per iteration
  a_sync_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_sync_valid |=> !o_sync_valid);

endmodule

`default_nettype wire

// File: tile_monitor_top.sv
// Top level of the tile monitor with per-tile console logic, line drain and profiler
`timescale 1ns/1ps
`default_nettype none

module tile_monitor_top (
  input  logic                                                       clk,
  input  logic                                                       i_rst_n,
  input  logic [tile_mon_pkg::N_TILES-1:0]                           i_aw_valid,
  input  logic [tile_mon_pkg::N_TILES-1:0][tile_mon_pkg::ADDR_W-1:0]  i_aw_addr,
  input  logic [tile_mon_pkg::N_TILES-1:0]                           i_w_valid,
  input  logic [tile_mon_pkg::N_TILES-1:0][tile_mon_pkg::DATA_W-1:0]  i_w_data,
  input  logic [tile_mon_pkg::N_TILES-1:0]                           i_ex_valid,
  input  logic [tile_mon_pkg::N_TILES-1:0][tile_mon_pkg::INSTR_W-1:0] i_ex_instr,
  output logic [tile_mon_pkg::N_TILES-1:0]                           o_exit_valid,
  output logic [tile_mon_pkg::N_TILES-1:0][tile_mon_pkg::CHAR_W-1:0]  o_exit_code,
  output logic                                                       o_out_valid,
  output logic [tile_mon_pkg::TILE_W-1:0]                            o_out_tile,
  output logic [tile_mon_pkg::CHAR_W-1:0]                            o_out_char,
  output logic                                                       o_out_last,
  output logic                                                       o_sync_valid,
  output logic [tile_mon_pkg::CYCLE_W-1:0]                           o_sync_cycles
);
  import tile_mon_pkg::*;

  logic [N_TILES-1:0]             char_valid;
  logic [N_TILES-1:0][CHAR_W-1:0] char_data;
  logic [N_TILES-1:0]             line_ready;
  logic [N_TILES-1:0][CHAR_W-1:0] head_char;
  logic [N_TILES-1:0]             pop;

  // Console path, one decoder and one line store per tile
  for (genvar t = 0; t < N_TILES; t++) begin : gen_tile
    console_decoder console_decoder_inst (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_aw_valid   (i_aw_valid[t]),
      .i_aw_addr    (i_aw_addr[t]),
      .i_w_valid    (i_w_valid[t]),
      .i_w_data     (i_w_data[t]),
      .o_char_valid (char_valid[t]),
      .o_char_data  (char_data[t]),
      .o_exit_valid (o_exit_valid[t]),
      .o_exit_code  (o_exit_code[t])
    );

    console_line_buffer console_line_buffer_inst (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_push       (char_valid[t]),
      .i_char       (char_data[t]),
      .i_pop        (pop[t]),
      .o_line_ready (line_ready[t]),
      .o_head_char  (head_char[t])
    );
  end

  // Single shared character stream
  console_line_drain console_line_drain_inst (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_line_ready (line_ready),
    .i_head_char  (head_char),
    .o_pop        (pop),
    .o_out_valid  (o_out_valid),
    .o_out_tile   (o_out_tile),
    .o_out_char   (o_out_char),
    .o_out_last   (o_out_last)
  );

  sync_profiler sync_profiler_inst (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_ex_valid    (i_ex_valid),
    .i_ex_instr    (i_ex_instr),
    .o_sync_valid  (o_sync_valid),
    .o_sync_cycles (o_sync_cycles)
  );

endmodule

`default_nettype wire

// File: tb_monitor_checker.sv
// Checker that compares the monitor's console, exit and sync outputs with the expected events
`timescale 1ns/1ps
`default_nettype none

module tb_monitor_checker (
  input  logic                                                        clk,
  input  logic                                                        i_rst_n,
  input  logic                                                        i_out_valid,
  input  logic [tile_mon_pkg::TILE_W-1:0]                             i_out_tile,
  input  logic [tile_mon_pkg::CHAR_W-1:0]                             i_out_char,
  input  logic                                                        i_out_last,
  input  logic [tile_mon_pkg::N_TILES-1:0]                            i_exit_valid,
  input  logic [tile_mon_pkg::N_TILES-1:0][tile_mon_pkg::CHAR_W-1:0]  i_exit_code,
  input  logic                                                        i_sync_valid,
  input  logic [tile_mon_pkg::CYCLE_W-1:0]                            i_sync_cycles,
  input  logic [tile_mon_pkg::N_TILES-1:0]                            i_exp_char_valid,
  input  logic [tile_mon_pkg::N_TILES-1:0][tile_mon_pkg::CHAR_W-1:0]  i_exp_char,
  input  logic [tile_mon_pkg::N_TILES-1:0]                            i_exp_exit_valid,
  input  logic [tile_mon_pkg::N_TILES-1:0][tile_mon_pkg::CHAR_W-1:0]  i_exp_exit_code,
  input  logic                                                        i_exp_sync_valid,
  input  logic [tile_mon_pkg::CYCLE_W-1:0]                            i_exp_sync_cycles,
  input  logic                                                        i_done,
  output logic                                                        o_reported,
  output int                                                          o_errors
);
  import tile_mon_pkg::*;

  logic [CHAR_W-1:0]  char_q [N_TILES][$];
  logic [CYCLE_W-1:0] sync_q [$];
  int                 sync_due_q [$];
  logic [N_TILES-1:0] exit_exp;
  logic [N_TILES-1:0] exit_seen;
  logic [N_TILES-1:0] exit_prev;
  logic [CHAR_W-1:0]  exit_code_exp [N_TILES];
  logic               in_line;
  logic [TILE_W-1:0]  line_tile;
  logic [CHAR_W-1:0]  want;
  int                 err [5];
  int                 cyc;
  int                 lines_done;
  int                 syncs_done;

  function automatic string verdict(input int e);
    return (e == 0) ? "pass" : "fail";
  endfunction

  always @(posedge clk) begin
    if (!i_rst_n) begin
      cyc       = 0;
      exit_exp  = '0;
      exit_seen = '0;
      exit_prev = '0;
      in_line   = 1'b0;
    end else begin
      cyc = cyc + 1;
      for (int t = 0; t < N_TILES; t++) begin
        if (i_exp_char_valid[t]) begin
          char_q[t].push_back(i_exp_char[t]);
        end
        if (i_exp_exit_valid[t]) begin
          exit_exp[t]      = 1'b1;
          exit_code_exp[t] = i_exp_exit_code[t];
        end
      end
      if (i_exp_sync_valid) begin
        sync_q.push_back(i_exp_sync_cycles);
        sync_due_q.push_back(cyc + 1);
      end
      // Console stream
      if (i_out_valid) begin
        if (in_line && i_out_tile != line_tile) begin
          $display("mismatch o_out_tile inside a line: got %h expected %h", i_out_tile, line_tile);
          err[1]++;
        end
        if (char_q[i_out_tile].size() == 0) begin
          $display("character %h from tile %0d has no console write behind it",
                   i_out_char, i_out_tile);
          err[3]++;
        end else begin
          want = char_q[i_out_tile].pop_front();
          if (i_out_char != want) begin
            $display("mismatch o_out_char tile %0d: got %h expected %h", i_out_tile, i_out_char, want);
            err[0]++;
          end
          if (i_out_last != (want == NEWLINE_CHAR)) begin
            $display("mismatch o_out_last tile %0d: got %h expected %h", i_out_tile, i_out_last,
                     want == NEWLINE_CHAR);
            err[0]++;
          end
        end
        in_line   = !i_out_last;
        line_tile = i_out_tile;
        if (i_out_last) begin
          lines_done++;
        end
      end
      // Exit codes on the rising edge of each flag
      for (int t = 0; t < N_TILES; t++) begin
        if (i_exit_valid[t] && !exit_prev[t]) begin
          exit_seen[t] = 1'b1;
          if (!exit_exp[t]) begin
            $display("exit flag of tile %0d rose without a stderr write", t);
            err[3]++;
          end else if (i_exit_code[t] != exit_code_exp[t]) begin
            $display("mismatch o_exit_code tile %0d: got %h expected %h", t, i_exit_code[t],
                     exit_code_exp[t]);
            err[2]++;
          end
        end
      end
      exit_prev = i_exit_valid;
      // Sync reports, each due one cycle after the last end sentinel
      if (sync_due_q.size() != 0 && sync_due_q[0] < cyc) begin
        $display("sync report missing for an iteration");
        err[4]++;
        void'(sync_due_q.pop_front());
        void'(sync_q.pop_front());
      end
      if (i_sync_valid) begin
        if (sync_due_q.size() == 0 || sync_due_q[0] != cyc) begin
          $display("sync report came at the wrong time");
          err[4]++;
        end else begin
          if (i_sync_cycles != sync_q[0]) begin
            $display("mismatch o_sync_cycles: got %h expected %h", i_sync_cycles, sync_q[0]);
            err[4]++;
          end
          void'(sync_due_q.pop_front());
          void'(sync_q.pop_front());
          syncs_done++;
        end
      end
    end
  end

  initial begin
    o_reported = 1'b0;
    o_errors   = 0;
    wait (i_done);
    @(posedge clk);
    for (int t = 0; t < N_TILES; t++) begin
      if (char_q[t].size() != 0) begin
        $display("tile %0d still has %0d characters that never left the monitor",
                 t, char_q[t].size());
        err[0]++;
      end
      if (exit_exp[t] && !exit_seen[t]) begin
        $display("exit code of tile %0d never appeared", t);
        err[2]++;
      end
    end
    if (in_line) begin
      $display("the stream stopped in the middle of a line");
      err[1]++;
    end
    if (sync_q.size() != 0) begin
      $display("%0d sync reports never appeared", sync_q.size());
      err[4]++;
    end
    $display("console lines   : %s (%0d lines, %0d errors)", verdict(err[0]), lines_done, err[0]);
    $display("whole lines     : %s (%0d errors)", verdict(err[1]), err[1]);
    $display("exit codes      : %s (%0d tiles, %0d errors)", verdict(err[2]), $countones(exit_seen),
             err[2]);
    $display("unmatched writes: %s (%0d errors)", verdict(err[3]), err[3]);
    $display("sync report     : %s (%0d reports, %0d errors)", verdict(err[4]), syncs_done, err[4]);
    o_errors = err[0] + err[1] + err[2] + err[3] + err[4];
    $display("summary: 5 tests, %0d errors", o_errors);
    o_reported = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_tile_monitor.sv
// Testbench top with clock, reset, random console and sentinel stimulus and a watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_tile_monitor;
  import tile_mon_pkg::*;

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 10;
  localparam int CONSOLE_CYCLES  = 2000;
  localparam int FLUSH_CYCLES    = 40;
  localparam int SYNC_ITERS      = 30;
  localparam int ITER_CYCLES     = 24;
  localparam int DRAIN_MARGIN    = 400;
  localparam int CONSOLE_TOTAL   = CONSOLE_CYCLES + FLUSH_CYCLES;
  localparam int SYNC_TOTAL      = SYNC_ITERS * (ITER_CYCLES + 2);
  localparam int STIM_CYCLES     = (CONSOLE_TOTAL > SYNC_TOTAL) ? CONSOLE_TOTAL : SYNC_TOTAL;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + STIM_CYCLES + DRAIN_MARGIN;

  logic                             clk;
  logic                             i_rst_n;
  logic [N_TILES-1:0]               i_aw_valid;
  logic [N_TILES-1:0][ADDR_W-1:0]   i_aw_addr;
  logic [N_TILES-1:0]               i_w_valid;
  logic [N_TILES-1:0][DATA_W-1:0]   i_w_data;
  logic [N_TILES-1:0]               i_ex_valid;
  logic [N_TILES-1:0][INSTR_W-1:0]  i_ex_instr;
  logic [N_TILES-1:0]               o_exit_valid;
  logic [N_TILES-1:0][CHAR_W-1:0]   o_exit_code;
  logic                             o_out_valid;
  logic [TILE_W-1:0]                o_out_tile;
  logic [CHAR_W-1:0]                o_out_char;
  logic                             o_out_last;
  logic                             o_sync_valid;
  logic [CYCLE_W-1:0]               o_sync_cycles;

  // Expected events handed to the checker
  logic [N_TILES-1:0]               exp_char_valid;
  logic [N_TILES-1:0][CHAR_W-1:0]   exp_char;
  logic [N_TILES-1:0]               exp_exit_valid;
  logic [N_TILES-1:0][CHAR_W-1:0]   exp_exit_code;
  logic                             exp_sync_valid;
  logic [CYCLE_W-1:0]               exp_sync_cycles;
  logic                             run_done;
  logic                             reported;
  int                               errors;

  // Per-tile stimulus state
  logic [N_TILES-1:0]               arm_pend;
  logic [N_TILES-1:0]               pend_err;
  logic [N_TILES-1:0][CHAR_W-1:0]   pend_byte;
  logic [N_TILES-1:0]               line_open;
  logic [N_TILES-1:0]               exit_sent;
  int                               line_left [N_TILES];
  int                               nl_sent [N_TILES];
  int                               nl_drained [N_TILES];

  tile_monitor_top tile_monitor_top_inst (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_aw_valid    (i_aw_valid),
    .i_aw_addr     (i_aw_addr),
    .i_w_valid     (i_w_valid),
    .i_w_data      (i_w_data),
    .i_ex_valid    (i_ex_valid),
    .i_ex_instr    (i_ex_instr),
    .o_exit_valid  (o_exit_valid),
    .o_exit_code   (o_exit_code),
    .o_out_valid   (o_out_valid),
    .o_out_tile    (o_out_tile),
    .o_out_char    (o_out_char),
    .o_out_last    (o_out_last),
    .o_sync_valid  (o_sync_valid),
    .o_sync_cycles (o_sync_cycles)
  );

  tb_monitor_checker tb_monitor_checker_inst (
    .clk               (clk),
    .i_rst_n           (i_rst_n),
    .i_out_valid       (o_out_valid),
    .i_out_tile        (o_out_tile),
    .i_out_char        (o_out_char),
    .i_out_last        (o_out_last),
    .i_exit_valid      (o_exit_valid),
    .i_exit_code       (o_exit_code),
    .i_sync_valid      (o_sync_valid),
    .i_sync_cycles     (o_sync_cycles),
    .i_exp_char_valid  (exp_char_valid),
    .i_exp_char        (exp_char),
    .i_exp_exit_valid  (exp_exit_valid),
    .i_exp_exit_code   (exp_exit_code),
    .i_exp_sync_valid  (exp_sync_valid),
    .i_exp_sync_cycles (exp_sync_cycles),
    .i_done            (run_done),
    .o_reported        (reported),
    .o_errors          (errors)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the run finished");
    $display("TEST FAILED");
    $finish;
  end

  // Count completed lines per tile to throttle new ones
  always @(posedge clk) begin
    if (i_rst_n && o_out_valid && o_out_last) begin
      nl_drained[o_out_tile] <= nl_drained[o_out_tile] + 1;
    end
  end

  function automatic logic lines_pending();
    logic busy;
    busy = 1'b0;
    for (int t = 0; t < N_TILES; t++) begin
      if (nl_sent[t] != nl_drained[t]) begin
        busy = 1'b1;
      end
    end
    return busy;
  endfunction

  task automatic send_console_traffic();
    int                             cyc;
    int                             r;
    logic                           flush;
    logic [CHAR_W-1:0]              ch;
    logic [DATA_W-1:0]              data;
    logic [N_TILES-1:0]             aw_v;
    logic [N_TILES-1:0]             w_v;
    logic [N_TILES-1:0]             cv;
    logic [N_TILES-1:0]             ev;
    logic [N_TILES-1:0][ADDR_W-1:0] aw_a;
    logic [N_TILES-1:0][DATA_W-1:0] w_d;
    logic [N_TILES-1:0][CHAR_W-1:0] cch;
    logic [N_TILES-1:0][CHAR_W-1:0] ecode;
    cyc = 0;
    while (cyc < CONSOLE_CYCLES || (|line_open) || (|arm_pend)) begin
      @(posedge clk);
      flush = (cyc >= CONSOLE_CYCLES);
      aw_v  = '0;
      w_v   = '0;
      cv    = '0;
      ev    = '0;
      cch   = '0;
      ecode = '0;
      for (int t = 0; t < N_TILES; t++) begin
        r       = flush ? 0 : int'($urandom % 16);
        data    = $urandom;
        // Idle address never hits the console range
        aw_a[t] = $urandom & 32'h7FFF_FFFF;
        w_d[t]  = data;
        if (arm_pend[t]) begin
          if (r < 8) begin
            w_v[t]      = 1'b1;
            w_d[t]      = {data[DATA_W-1:CHAR_W], pend_byte[t]};
            arm_pend[t] = 1'b0;
            if (pend_err[t]) begin
              ev[t]    = 1'b1;
              ecode[t] = pend_byte[t];
            end else begin
              cv[t]  = 1'b1;
              cch[t] = pend_byte[t];
            end
          end
        end else if (r < 5 && (line_open[t] || (!flush && nl_sent[t] == nl_drained[t]))) begin
          if (!line_open[t]) begin
            line_open[t] = 1'b1;
            line_left[t] = int'($urandom % 16);
          end
          if (line_left[t] == 0) begin
            ch           = NEWLINE_CHAR;
            line_open[t] = 1'b0;
            nl_sent[t]   = nl_sent[t] + 1;
          end else begin
            ch           = 8'h20 + 8'($urandom % 95);
            line_left[t] = line_left[t] - 1;
          end
          aw_v[t] = 1'b1;
          aw_a[t] = STDOUT_ADDR;
          if ($urandom % 2 == 0) begin
            w_v[t] = 1'b1;
            w_d[t] = {data[DATA_W-1:CHAR_W], ch};
            cv[t]  = 1'b1;
            cch[t] = ch;
          end else begin
            arm_pend[t]  = 1'b1;
            pend_err[t]  = 1'b0;
            pend_byte[t] = ch;
          end
        end else if (r == 5) begin
          // Write to an unrelated address
          aw_v[t] = 1'b1;
          w_v[t]  = 1'b1;
        end else if (r == 6) begin
          w_v[t] = 1'b1;
        end else if (r == 7 && !exit_sent[t] && !flush && $urandom % 32 == 0) begin
          exit_sent[t] = 1'b1;
          ch           = 8'($urandom);
          aw_v[t]      = 1'b1;
          aw_a[t]      = STDERR_ADDR;
          if ($urandom % 2 == 0) begin
            w_v[t]   = 1'b1;
            w_d[t]   = {data[DATA_W-1:CHAR_W], ch};
            ev[t]    = 1'b1;
            ecode[t] = ch;
          end else begin
            arm_pend[t]  = 1'b1;
            pend_err[t]  = 1'b1;
            pend_byte[t] = ch;
          end
        end
      end
      i_aw_valid     <= aw_v;
      i_aw_addr      <= aw_a;
      i_w_valid      <= w_v;
      i_w_data       <= w_d;
      exp_char_valid <= cv;
      exp_char       <= cch;
      exp_exit_valid <= ev;
      exp_exit_code  <= ecode;
      cyc = cyc + 1;
    end
    @(posedge clk);
    i_aw_valid     <= '0;
    i_w_valid      <= '0;
    exp_char_valid <= '0;
    exp_exit_valid <= '0;
  endtask

  task automatic play_sync_iterations();
    int                              st [N_TILES];
    int                              en [N_TILES];
    int                              max_s;
    int                              max_e;
    logic [N_TILES-1:0]              v;
    logic [N_TILES-1:0][INSTR_W-1:0] ins;
    for (int it = 0; it < SYNC_ITERS; it++) begin
      max_s = 0;
      max_e = 0;
      for (int t = 0; t < N_TILES; t++) begin
        st[t] = int'($urandom % 10);
        en[t] = 10 + int'($urandom % 14);
        max_s = (st[t] > max_s) ? st[t] : max_s;
        max_e = (en[t] > max_e) ? en[t] : max_e;
      end
      for (int c = 0; c < ITER_CYCLES; c++) begin
        @(posedge clk);
        for (int t = 0; t < N_TILES; t++) begin
          ins[t] = $urandom;
          if (ins[t] == SENT_START || ins[t] == SENT_END) begin
            ins[t][31] = ~ins[t][31];
          end
          v[t] = ($urandom % 2 == 0);
          // Sentinel encodings with valid low must be ignored
          if ($urandom % 4 == 0) begin
            ins[t] = ($urandom % 2 == 0) ? SENT_START : SENT_END;
            v[t]   = 1'b0;
          end
          if (c == st[t]) begin
            v[t]   = 1'b1;
            ins[t] = SENT_START;
          end
          if (c == en[t]) begin
            v[t]   = 1'b1;
            ins[t] = SENT_END;
          end
        end
        i_ex_valid      <= v;
        i_ex_instr      <= ins;
        exp_sync_valid  <= (c == max_e);
        exp_sync_cycles <= CYCLE_W'(max_e - max_s - SENT_OVERHEAD);
      end
      @(posedge clk);
      i_ex_valid     <= '0;
      exp_sync_valid <= 1'b0;
      @(posedge clk);
    end
  endtask

  initial begin
    void'($urandom(3049));
    i_rst_n         = 1'b0;
    i_aw_valid      = '0;
    i_aw_addr       = '0;
    i_w_valid       = '0;
    i_w_data        = '0;
    i_ex_valid      = '0;
    i_ex_instr      = '0;
    exp_char_valid  = '0;
    exp_char        = '0;
    exp_exit_valid  = '0;
    exp_exit_code   = '0;
    exp_sync_valid  = 1'b0;
    exp_sync_cycles = '0;
    run_done        = 1'b0;
    arm_pend        = '0;
    pend_err        = '0;
    pend_byte       = '0;
    line_open       = '0;
    exit_sent       = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    i_rst_n <= 1'b1;
    fork
      send_console_traffic();
      play_sync_iterations();
    join
    while (lines_pending()) begin
      @(posedge clk);
    end
    repeat (8) @(posedge clk);
    run_done <= 1'b1;
    wait (reported);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
tile_mon_pkg.sv
console_decoder.sv
console_line_buffer.sv
console_line_drain.sv
sync_profiler.sv
tile_monitor_top.sv
tb_monitor_checker.sv
tb_tile_monitor.sv

// File: Makefile
# Verilator build and run for the tile monitor testbench

VERILATOR  ?= verilator
TOP        ?= tb_tile_monitor
RTL_TOP    ?= tile_monitor_top
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
